//--- rtl/axi_cfg_pkg.sv
// ==================================================
// Widths, counts and slave decode position
// for the two-master AXI read crossbar
// ==================================================
package axi_cfg_pkg;

	// ==================================================
	// Port counts
	// ==================================================
	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES  = 2;

	// Index widths derived from the counts
	localparam int MIDX_BITS = $clog2(NUM_MASTERS);
	localparam int SIDX_BITS = $clog2(NUM_SLAVES);

	// ==================================================
	// Channel field widths
	// ==================================================
	// Transaction ID as the masters see it
	localparam int ID_BITS   = 4;
	// Slave side carries the master index on top
	localparam int IDS_BITS  = ID_BITS + MIDX_BITS;
	localparam int ADDR_BITS = 32;
	localparam int DATA_BITS = 32;
	localparam int LEN_BITS  = 8;
	localparam int SIZE_BITS = 3;

	// ==================================================
	// Address decode
	// ==================================================
	// Bit 16 clear selects S0, set selects S1
	localparam int SLAVE_SEL_BIT = 16;

endpackage

//--- rtl/axi_chan_pkg.sv
// ==================================================
// AR and R channel payload structs, burst and
// response encodings, return path states
// ==================================================
package axi_chan_pkg;

	import axi_cfg_pkg::*;

	// ==================================================
	// Encodings
	// ==================================================
	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} axi_burst_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// Return path burst lock
	typedef enum logic [0:0] {
		R_IDLE,
		R_BURST
	} r_state_e;

	// ==================================================
	// Read address payloads
	// ==================================================
	// Master side, 49 bits
	typedef struct packed {
		logic [ID_BITS-1:0]   id;
		logic [ADDR_BITS-1:0] addr;
		logic [LEN_BITS-1:0]  len;
		logic [SIZE_BITS-1:0] size;
		axi_burst_e           burst;
	} ar_req_t;

	// Slave side, master index in the top id bit
	typedef struct packed {
		logic [IDS_BITS-1:0]  id;
		logic [ADDR_BITS-1:0] addr;
		logic [LEN_BITS-1:0]  len;
		logic [SIZE_BITS-1:0] size;
		axi_burst_e           burst;
	} ar_req_s_t;

	// ==================================================
	// Read data payloads
	// ==================================================
	typedef struct packed {
		logic [ID_BITS-1:0]   id;
		logic [DATA_BITS-1:0] data;
		axi_resp_e            resp;
		logic                 last;
	} r_beat_t;

	typedef struct packed {
		logic [IDS_BITS-1:0]  id;
		logic [DATA_BITS-1:0] data;
		axi_resp_e            resp;
		logic                 last;
	} r_beat_s_t;

endpackage

//--- rtl/ar_arbiter.sv
// ==================================================
// Round-robin read address arbiter with
// master index tagging of the ID
// ==================================================
`timescale 1ns/100ps

module ar_arbiter (
	input  logic                                ACLK,
	input  logic                                ARESETn,
	// Master side
	input  axi_chan_pkg::ar_req_t               m_ar [axi_cfg_pkg::NUM_MASTERS],
	input  logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_arvalid,
	output logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_arready,
	// Toward the decoder
	output axi_chan_pkg::ar_req_s_t             sel_ar,
	output logic                                sel_valid,
	input  logic                                sel_ready
);

	import axi_cfg_pkg::*;
	import axi_chan_pkg::*;

	// Master served by the last accepted request
	logic [MIDX_BITS-1:0] last_gnt;
	logic [MIDX_BITS-1:0] gnt_idx;
	ar_req_t              gnt_ar;
	logic                 accept;

	// ==================================================
	// Grant selection
	// ==================================================
	always_comb begin
		if (m_arvalid[0] && m_arvalid[1]) begin
			// Both waiting so the one not served last wins
			gnt_idx = ~last_gnt;
		end else if (m_arvalid[1]) begin
			gnt_idx = MIDX_BITS'(1);
		end else begin
			gnt_idx = '0;
		end
	end

	assign gnt_ar    = m_ar[gnt_idx];
	assign sel_valid = |m_arvalid;
	assign accept    = sel_valid && sel_ready;

	// Forward the granted request with its index on top of the ID
	always_comb begin
		sel_ar.id    = {gnt_idx, gnt_ar.id};
		sel_ar.addr  = gnt_ar.addr;
		sel_ar.len   = gnt_ar.len;
		sel_ar.size  = gnt_ar.size;
		sel_ar.burst = gnt_ar.burst;
	end

	// Only the granted master sees the downstream ready
	always_comb begin
		for (int i = 0; i < NUM_MASTERS; i++) begin
			m_arready[i] = sel_ready && m_arvalid[i] && (gnt_idx == MIDX_BITS'(i));
		end
	end

	// ==================================================
	// Pointer update
	// ==================================================
	// Starts at the last master so M0 goes first
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			last_gnt <= '1;
		end else if (accept) begin
			last_gnt <= gnt_idx;
		end
	end

endmodule

//--- rtl/ar_decoder.sv
// ==================================================
// Address decode to one slave and a one-entry
// hold register for the outgoing AR request
// ==================================================
`timescale 1ns/100ps

module ar_decoder (
	input  logic                               ACLK,
	input  logic                               ARESETn,
	// From the arbiter
	input  axi_chan_pkg::ar_req_s_t            sel_ar,
	input  logic                               sel_valid,
	output logic                               sel_ready,
	// Slave side
	output axi_chan_pkg::ar_req_s_t            s_ar [axi_cfg_pkg::NUM_SLAVES],
	output logic [axi_cfg_pkg::NUM_SLAVES-1:0] s_arvalid,
	input  logic [axi_cfg_pkg::NUM_SLAVES-1:0] s_arready
);

	import axi_cfg_pkg::*;
	import axi_chan_pkg::*;

	ar_req_s_t            hold_ar;
	logic                 hold_valid;
	logic [SIDX_BITS-1:0] hold_slv;
	logic                 drain;
	logic                 load;

	// Target slave accepts the held request
	assign drain     = hold_valid && s_arready[hold_slv];
	// Empty slot or one emptying this cycle
	assign sel_ready = !hold_valid || drain;
	assign load      = sel_valid && sel_ready;

	// ==================================================
	// Hold register
	// ==================================================
	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			hold_valid <= 1'b0;
			hold_slv   <= '0;
		end else if (load) begin
			hold_valid <= 1'b1;
			hold_slv   <= sel_ar.addr[SLAVE_SEL_BIT +: SIDX_BITS];
		end else if (drain) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge ACLK) begin
		if (load) begin
			hold_ar <= sel_ar;
		end
	end

	// ==================================================
	// Slave outputs
	// ==================================================
	always_comb begin
		for (int i = 0; i < NUM_SLAVES; i++) begin
			s_ar[i]      = hold_ar;
			s_arvalid[i] = hold_valid && (hold_slv == SIDX_BITS'(i));
		end
	end

endmodule

//--- rtl/r_return.sv
// ==================================================
// Read data return path with burst lock, ID
// routing to the master and an output register
// ==================================================
`timescale 1ns/100ps

module r_return (
	input  logic                                ACLK,
	input  logic                                ARESETn,
	// Slave side
	input  axi_chan_pkg::r_beat_s_t             s_r [axi_cfg_pkg::NUM_SLAVES],
	input  logic [axi_cfg_pkg::NUM_SLAVES-1:0]  s_rvalid,
	output logic [axi_cfg_pkg::NUM_SLAVES-1:0]  s_rready,
	// Master side
	output axi_chan_pkg::r_beat_t               m_r [axi_cfg_pkg::NUM_MASTERS],
	output logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_rvalid,
	input  logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_rready
);

	import axi_cfg_pkg::*;
	import axi_chan_pkg::*;

	r_state_e             state;
	r_state_e             state_next;
	logic [SIDX_BITS-1:0] cur_slv;
	logic [SIDX_BITS-1:0] idle_pick;
	logic [SIDX_BITS-1:0] src_slv;
	logic                 src_valid;
	r_beat_s_t            src_beat;

	// Output beat register
	r_beat_t              out_beat;
	logic [MIDX_BITS-1:0] out_mst;
	logic                 out_valid;
	logic                 out_drain;
	logic                 space;
	logic                 take;

	// ==================================================
	// Source selection
	// ==================================================
	// Lowest index wins so S0 has priority
	always_comb begin
		idle_pick = '0;
		for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
			if (s_rvalid[i]) begin
				idle_pick = SIDX_BITS'(i);
			end
		end
	end

	// Locked slave for the rest of a burst
	assign src_slv   = (state == R_BURST) ? cur_slv : idle_pick;
	assign src_valid = s_rvalid[src_slv];
	assign src_beat  = s_r[src_slv];

	assign out_drain = out_valid && m_rready[out_mst];
	assign space     = !out_valid || out_drain;
	assign take      = src_valid && space;

	always_comb begin
		for (int i = 0; i < NUM_SLAVES; i++) begin
			s_rready[i] = space && src_valid && (src_slv == SIDX_BITS'(i));
		end
	end

	// ==================================================
	// Burst lock FSM
	// ==================================================
	always_comb begin
		state_next = state;
		unique case (state)
			R_IDLE: begin
				if (take && !src_beat.last) begin
					state_next = R_BURST;
				end
			end
			R_BURST: begin
				if (take && src_beat.last) begin
					state_next = R_IDLE;
				end
			end
			default: state_next = R_IDLE;
		endcase
	end

	always_ff @(posedge ACLK or negedge ARESETn) begin
		if (!ARESETn) begin
			state     <= R_IDLE;
			cur_slv   <= '0;
			out_valid <= 1'b0;
			out_mst   <= '0;
		end else begin
			state <= state_next;
			if (state == R_IDLE && take) begin
				cur_slv <= src_slv;
			end
			if (take) begin
				out_valid <= 1'b1;
				out_mst   <= src_beat.id[IDS_BITS-1 -: MIDX_BITS];
			end else if (out_drain) begin
				out_valid <= 1'b0;
			end
		end
	end

	// Tag stripped on the way into the register
	always_ff @(posedge ACLK) begin
		if (take) begin
			out_beat.id   <= src_beat.id[ID_BITS-1:0];
			out_beat.data <= src_beat.data;
			out_beat.resp <= src_beat.resp;
			out_beat.last <= src_beat.last;
		end
	end

	// ==================================================
	// Master outputs
	// ==================================================
	always_comb begin
		for (int i = 0; i < NUM_MASTERS; i++) begin
			m_r[i]      = out_beat;
			m_rvalid[i] = out_valid && (out_mst == MIDX_BITS'(i));
		end
	end

endmodule

//--- rtl/axi_read_xbar.sv
// ==================================================
// Top level of the AXI read crossbar, two masters
// to two slaves on the AR and R channels
// ==================================================
`timescale 1ns/100ps

module axi_read_xbar (
	input  logic                                ACLK,
	input  logic                                ARESETn,

	// ==================================================
	// Master ports
	// ==================================================
	input  axi_chan_pkg::ar_req_t               m_ar [axi_cfg_pkg::NUM_MASTERS],
	input  logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_arvalid,
	output logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_arready,
	output axi_chan_pkg::r_beat_t               m_r [axi_cfg_pkg::NUM_MASTERS],
	output logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_rvalid,
	input  logic [axi_cfg_pkg::NUM_MASTERS-1:0] m_rready,

	// ==================================================
	// Slave ports
	// ==================================================
	output axi_chan_pkg::ar_req_s_t             s_ar [axi_cfg_pkg::NUM_SLAVES],
	output logic [axi_cfg_pkg::NUM_SLAVES-1:0]  s_arvalid,
	input  logic [axi_cfg_pkg::NUM_SLAVES-1:0]  s_arready,
	input  axi_chan_pkg::r_beat_s_t             s_r [axi_cfg_pkg::NUM_SLAVES],
	input  logic [axi_cfg_pkg::NUM_SLAVES-1:0]  s_rvalid,
	output logic [axi_cfg_pkg::NUM_SLAVES-1:0]  s_rready
);

	import axi_chan_pkg::*;

	// Arbiter to decoder link
	ar_req_s_t sel_ar;
	logic      sel_valid;
	logic      sel_ready;

	// Read address path
	ar_arbiter ar_arbiter_inst (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.m_ar      (m_ar),
		.m_arvalid (m_arvalid),
		.m_arready (m_arready),
		.sel_ar    (sel_ar),
		.sel_valid (sel_valid),
		.sel_ready (sel_ready)
	);

	ar_decoder ar_decoder_inst (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.sel_ar    (sel_ar),
		.sel_valid (sel_valid),
		.sel_ready (sel_ready),
		.s_ar      (s_ar),
		.s_arvalid (s_arvalid),
		.s_arready (s_arready)
	);

	// Read data path
	r_return r_return_inst (
		.ACLK     (ACLK),
		.ARESETn  (ARESETn),
		.s_r      (s_r),
		.s_rvalid (s_rvalid),
		.s_rready (s_rready),
		.m_r      (m_r),
		.m_rvalid (m_rvalid),
		.m_rready (m_rready)
	);

endmodule

//--- test/tb_clock_gen.sv
// ==================================================
// Testbench clock and reset source
// ==================================================
`timescale 1ns/100ps

module tb_clock_gen (
	output logic ACLK,
	output logic ARESETn
);

	// 40 ns period
	initial begin
		ACLK = 1'b0;
		forever #20 ACLK = ~ACLK;
	end

	// Reset held for two rising edges
	initial begin
		ARESETn = 1'b0;
		repeat (2) @(posedge ACLK);
		ARESETn <= 1'b1;
	end

endmodule

//--- test/axi_read_xbar_assertions.sv
// ==================================================
// Handshake checks bound to the read crossbar
// ==================================================
`timescale 1ns/100ps

module axi_read_xbar_assertions (
	input logic                    ACLK,
	input logic                    ARESETn,
	input axi_chan_pkg::ar_req_s_t s_ar [2],
	input logic [1:0]              s_arvalid,
	input logic [1:0]              s_arready,
	input logic [1:0]              m_rvalid,
	input logic [1:0]              m_rready
);

	import axi_chan_pkg::*;

	for (genvar i = 0; i < 2; i++) begin : g_port
		// Request held with a stable payload until taken
		assert property (@(posedge ACLK) disable iff (!ARESETn)
			s_arvalid[i] && !s_arready[i] |=> s_arvalid[i] && $stable(s_ar[i]))
			else $error("s_arvalid dropped or s_ar changed before s_arready");

		assert property (@(posedge ACLK) disable iff (!ARESETn)
			m_rvalid[i] && !m_rready[i] |=> m_rvalid[i])
			else $error("m_rvalid dropped before m_rready");
	end

	// One slave addressed at a time
	assert property (@(posedge ACLK) disable iff (!ARESETn) !(&s_arvalid))
		else $error("both s_arvalid outputs high");

endmodule

bind axi_read_xbar axi_read_xbar_assertions assertions_inst (.*);

//--- test/axi_read_xbar_tb.sv
// ==================================================
// Read crossbar testbench with slave models,
// LFSR stimulus and directed tests
// ==================================================
`timescale 1ns/100ps

module axi_read_xbar_tb;

	import axi_cfg_pkg::*;
	import axi_chan_pkg::*;

	// Requests and beats over all tests set the run limit
	localparam int TOTAL_REQS     = 14;
	localparam int TOTAL_BEATS    = 35;
	localparam int TIMEOUT_CYCLES = 4 * (TOTAL_REQS + TOTAL_BEATS) + 200;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic                   ACLK;
	logic                   ARESETn;
	ar_req_t                m_ar [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] m_arvalid;
	logic [NUM_MASTERS-1:0] m_arready;
	r_beat_t                m_r [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] m_rvalid;
	logic [NUM_MASTERS-1:0] m_rready;
	ar_req_s_t              s_ar [NUM_SLAVES];
	logic [NUM_SLAVES-1:0]  s_arvalid;
	logic [NUM_SLAVES-1:0]  s_arready;
	r_beat_s_t              s_r [NUM_SLAVES];
	logic [NUM_SLAVES-1:0]  s_rvalid;
	logic [NUM_SLAVES-1:0]  s_rready;

	logic [31:0] lfsr = 32'hfec2;
	int          error_count = 0;
	int          cycles = 0;
	logic        rready_random = 1'b0;
	int unsigned min_delay [NUM_SLAVES];
	ar_req_t     pend [NUM_MASTERS][$];
	ar_req_t     outst [NUM_MASTERS][$];
	ar_req_s_t   exp_ar [NUM_SLAVES][$];
	int          grant_log [$];
	int          cur_req [NUM_MASTERS];
	int          beat_idx [NUM_MASTERS];
	logic        in_burst [NUM_MASTERS];

	tb_clock_gen tb_clock_gen_inst (.ACLK(ACLK), .ARESETn(ARESETn));

	axi_read_xbar axi_read_xbar_inst (.*);

	// ==================================================
	// Helpers
	// ==================================================
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] bits;
		logic        out;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			out  = lfsr[0];
			lfsr = {1'b0, lfsr[31:1]};
			if (out) begin
				lfsr = lfsr ^ LFSR_TAPS;
			end
			bits = {bits[30:0], out};
		end
		return bits;
	endfunction

	// Data a slave returns for one beat
	function automatic logic [31:0] beat_data(input logic [31:0] addr, input int idx);
		return (addr + 32'(idx) * 32'd4) ^ 32'hc3a5_0000;
	endfunction

	function automatic ar_req_t make_req(input logic [3:0] id, input logic [31:0] addr,
			input logic [7:0] len);
		ar_req_t r;
		r.id    = id;
		r.addr  = addr;
		r.len   = len;
		r.size  = 3'd2;
		r.burst = BURST_INCR;
		return r;
	endfunction

	task automatic fail_value(input string msg);
		error_count++;
		$display("error at %0t ns: %s", $time, msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	// ==================================================
	// Slave model
	// ==================================================
	task automatic serve_slave(input int s);
		ar_req_s_t   first;
		ar_req_s_t   req;
		r_beat_s_t   beat;
		int unsigned wait_n;
		forever begin
			@(posedge ACLK);
			if (ARESETn && s_arvalid[s]) begin
				first  = s_ar[s];
				wait_n = min_delay[s] + lfsr_take(2);
				repeat (wait_n) begin
					@(posedge ACLK);
					assert (s_arvalid[s] && s_ar[s] == first)
						else fail_value("AR request changed while the slave stalled");
				end
				s_arready[s] <= 1'b1;
				@(posedge ACLK);
				req = s_ar[s];
				s_arready[s] <= 1'b0;
				assert (s_arvalid[s] && exp_ar[s].size() > 0)
					else fail_value($sformatf("unexpected AR at S%0d", s));
				assert (req == exp_ar[s][0])
					else fail_value($sformatf("wrong AR payload at S%0d", s));
				void'(exp_ar[s].pop_front());
				for (int b = 0; b <= int'(req.len); b++) begin
					beat.id   = req.id;
					beat.data = beat_data(req.addr, b);
					beat.resp = RESP_OKAY;
					beat.last = (b == int'(req.len));
					s_r[s]      <= beat;
					s_rvalid[s] <= 1'b1;
					do @(posedge ACLK); while (!s_rready[s]);
				end
				s_rvalid[s] <= 1'b0;
			end
		end
	endtask

	// ==================================================
	// Master side driving and checking
	// ==================================================
	task automatic drive_reads();
		logic [NUM_MASTERS-1:0] active;
		ar_req_t                r;
		ar_req_s_t              e;
		int                     slv;
		active = '0;
		@(posedge ACLK);
		for (int m = 0; m < NUM_MASTERS; m++) begin
			if (pend[m].size() > 0) begin
				m_ar[m]      <= pend[m][0];
				m_arvalid[m] <= 1'b1;
				active[m]    = 1'b1;
			end
		end
		while (active != '0) begin
			@(posedge ACLK);
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (active[m] && m_arready[m]) begin
					r       = pend[m].pop_front();
					slv     = int'(r.addr[SLAVE_SEL_BIT]);
					e.id    = {m[0], r.id};
					e.addr  = r.addr;
					e.len   = r.len;
					e.size  = r.size;
					e.burst = r.burst;
					exp_ar[slv].push_back(e);
					outst[m].push_back(r);
					grant_log.push_back(m);
					if (pend[m].size() > 0) begin
						m_ar[m] <= pend[m][0];
					end else begin
						m_arvalid[m] <= 1'b0;
						active[m]    = 1'b0;
					end
				end
			end
		end
	endtask

	task automatic check_beat(input int m, input r_beat_t beat);
		ar_req_t r;
		int      found;
		if (!in_burst[m]) begin
			found = -1;
			for (int k = 0; k < outst[m].size(); k++) begin
				if (outst[m][k].id == beat.id) begin
					found = k;
				end
			end
			assert (found >= 0)
				else fail_value($sformatf("beat at M%0d matches no outstanding read", m));
			cur_req[m]  = found;
			beat_idx[m] = 0;
			in_burst[m] = 1'b1;
		end
		r = outst[m][cur_req[m]];
		assert (beat.id == r.id && beat.data == beat_data(r.addr, beat_idx[m])
				&& beat.resp == RESP_OKAY)
			else fail_value($sformatf("wrong beat %0d at M%0d", beat_idx[m], m));
		assert (beat.last == (beat_idx[m] == int'(r.len)))
			else fail_value($sformatf("wrong last flag at M%0d", m));
		if (beat.last) begin
			outst[m].delete(cur_req[m]);
			in_burst[m] = 1'b0;
		end else begin
			beat_idx[m]++;
		end
	endtask

	task automatic watch_masters();
		logic [31:0] r;
		forever begin
			@(posedge ACLK);
			for (int m = 0; m < NUM_MASTERS; m++) begin
				if (m_rvalid[m] && m_rready[m]) begin
					check_beat(m, m_r[m]);
				end
			end
			r = lfsr_take(rready_random ? 2 : 0);
			m_rready <= rready_random ? r[1:0] : 2'b11;
		end
	endtask

	task automatic wait_done();
		while (outst[0].size() > 0 || outst[1].size() > 0) begin
			@(posedge ACLK);
		end
	endtask

	// ==================================================
	// Directed tests
	// ==================================================
	task automatic test_reset();
		@(posedge ARESETn);
		@(posedge ACLK);
		assert (m_arready == '0 && s_arvalid == '0 && m_rvalid == '0 && s_rready == '0)
			else fail_value("outputs not low after reset");
	endtask

	task automatic test_m0_to_s0();
		pend[0].push_back(make_req(4'h3, 32'h0000_1200, 8'd3));
		drive_reads();
		wait_done();
	endtask

	task automatic test_m1_stall();
		min_delay[1] = 3;
		pend[1].push_back(make_req(4'h9, 32'h0001_0480, 8'd2));
		drive_reads();
		wait_done();
		min_delay[1] = 0;
	endtask

	task automatic test_round_robin();
		grant_log.delete();
		pend[0].push_back(make_req(4'h1, 32'h0000_0100, 8'd1));
		pend[0].push_back(make_req(4'h2, 32'h0001_0200, 8'd1));
		pend[1].push_back(make_req(4'h5, 32'h0001_0300, 8'd1));
		pend[1].push_back(make_req(4'h6, 32'h0000_0400, 8'd1));
		drive_reads();
		wait_done();
		assert (grant_log.size() == 4 && grant_log[0] == 0 && grant_log[1] == 1
				&& grant_log[2] == 0 && grant_log[3] == 1)
			else fail_value("AR grants did not alternate starting with M0");
	endtask

	task automatic test_backpressure();
		rready_random = 1'b1;
		pend[0].push_back(make_req(4'h8, 32'h0000_2000, 8'd3));
		pend[0].push_back(make_req(4'h9, 32'h0001_2100, 8'd0));
		pend[0].push_back(make_req(4'ha, 32'h0000_2200, 8'd2));
		pend[0].push_back(make_req(4'hb, 32'h0001_2300, 8'd1));
		pend[1].push_back(make_req(4'hc, 32'h0001_3000, 8'd1));
		pend[1].push_back(make_req(4'hd, 32'h0000_3100, 8'd2));
		pend[1].push_back(make_req(4'he, 32'h0001_3200, 8'd0));
		pend[1].push_back(make_req(4'hf, 32'h0000_3300, 8'd3));
		drive_reads();
		wait_done();
		rready_random = 1'b0;
	endtask

	// ==================================================
	// Run control
	// ==================================================
	initial begin
		forever begin
			@(posedge ACLK);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("Timeout: reads still outstanding after %0d cycles", cycles);
				$display("Checks failed");
				$fatal(1);
			end
		end
	end

	initial begin
		m_arvalid = '0;
		m_rready  = 2'b11;
		s_arready = '0;
		s_rvalid  = '0;
		for (int i = 0; i < 2; i++) begin
			m_ar[i]      = '0;
			s_r[i]       = '0;
			min_delay[i] = 0;
			in_burst[i]  = 1'b0;
		end
		fork
			serve_slave(0);
			serve_slave(1);
			watch_masters();
		join_none
		test_reset();
		// Arbiter pointer still at its reset value here
		test_round_robin();
		test_m0_to_s0();
		test_m1_stall();
		test_backpressure();
		if (error_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- flist.f
rtl/axi_cfg_pkg.sv
rtl/axi_chan_pkg.sv
rtl/ar_arbiter.sv
rtl/ar_decoder.sv
rtl/r_return.sv
rtl/axi_read_xbar.sv
test/tb_clock_gen.sv
test/axi_read_xbar_assertions.sv
test/axi_read_xbar_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the read crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module axi_read_xbar_tb -f flist.f --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All checks passed" <<< "$output"; then
	exit 0
fi
exit 1
